//--- fixed_divider.sv
`default_nettype none

`include "ray_tracer_defs.svh"

module fixed_divider (
  input wire clk,
  input wire rst,
  input wire start,
  input wire ray_tracer_pkg::coord_t num,
  input wire ray_tracer_pkg::coord_t den,
  output ray_tracer_pkg::coord_t quot,
  output logic zero,
  output logic done
);
  localparam int DVD_W = `COORD_W + `FRAC_W;
  localparam int CNT_W = $clog2(`DIV_STEPS + 1);

  logic busy;
  logic neg;
  logic [CNT_W-1:0] cnt;
  // Dividend bits shift out at the top while quotient bits shift in below
  logic [DVD_W-1:0] dvd;
  logic [`COORD_W-1:0] dsr;
  logic [`COORD_W-1:0] rem;
  logic [`COORD_W:0] rem_sh;
  logic [`COORD_W-1:0] num_mag;
  logic [`COORD_W-1:0] den_mag;
  logic [`COORD_W-1:0] q_sat;

  always_comb begin
    num_mag = num[`COORD_W-1] ? `COORD_W'(-num) : num;
    den_mag = den[`COORD_W-1] ? `COORD_W'(-den) : den;
    rem_sh = {rem, dvd[DVD_W-1]};
    // Clamp quotients that do not fit Q8.8
    q_sat = (dvd > DVD_W'(2 ** (`COORD_W - 1) - 1)) ?
            `COORD_W'(2 ** (`COORD_W - 1) - 1) : dvd[`COORD_W-1:0];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      done <= 1'b0;
      zero <= 1'b0;
      cnt <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        dvd <= {num_mag, `FRAC_W'(0)};
        dsr <= den_mag;
        rem <= '0;
        neg <= num[`COORD_W-1] ^ den[`COORD_W-1];
        zero <= (den == '0);
        cnt <= CNT_W'(`DIV_STEPS);
        busy <= 1'b1;
      end else if (busy && cnt != '0) begin
        // Restoring step, the remainder stays below the divisor
        if (rem_sh >= {1'b0, dsr}) begin
          rem <= `COORD_W'(rem_sh - {1'b0, dsr});
          dvd <= {dvd[DVD_W-2:0], 1'b1};
        end else begin
          rem <= rem_sh[`COORD_W-1:0];
          dvd <= {dvd[DVD_W-2:0], 1'b0};
        end
        cnt <= cnt - 1'b1;
      end else if (busy) begin
        quot <= neg ? -q_sat : q_sat;
        done <= 1'b1;
        busy <= 1'b0;
      end
    end
  end
endmodule

`default_nettype wire

//--- ray_intersector.sv
`default_nettype none

`include "ray_tracer_defs.svh"

module ray_intersector (
  input wire clk,
  input wire rst,
  input wire start,
  input wire ray_tracer_pkg::coord_t org_x, org_y, org_z,
  input wire ray_tracer_pkg::coord_t dir_x, dir_y, dir_z,
  input wire ray_tracer_pkg::obj_idx_t num_objs,
  output ray_tracer_pkg::obj_idx_t rd_addr,
  input wire ray_tracer_pkg::axis_t rd_axis,
  input wire ray_tracer_pkg::coord_t rd_offset,
  input wire ray_tracer_pkg::color_t rd_emit,
  input wire ray_tracer_pkg::color_t rd_reflect,
  output logic hit_valid,
  output logic hit_any,
  output ray_tracer_pkg::coord_t hit_pos_x, hit_pos_y, hit_pos_z,
  output ray_tracer_pkg::axis_t hit_axis,
  output ray_tracer_pkg::color_t hit_emit,
  output ray_tracer_pkg::color_t hit_reflect
);
  import ray_tracer_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_FETCH, S_SETUP, S_DIV, S_POS} intx_state_t;

  intx_state_t state;
  obj_idx_t idx;

  // Nearest hit so far
  logic found;
  coord_t best_t;
  axis_t best_axis;
  color_t best_emit;
  color_t best_reflect;

  coord_t org_c;
  coord_t dir_c;
  logic div_start;
  coord_t div_quot;
  logic div_zero;
  logic div_done;
  logic closer;

  // Q8.8 product, arithmetic shift then truncate
  function automatic coord_t q_mul(input coord_t a, input coord_t b);
    logic signed [2*`COORD_W-1:0] prod;
    prod = a * b;
    return coord_t'(prod >>> `FRAC_W);
  endfunction

  assign rd_addr = idx;
  assign div_start = (state == S_SETUP);

  // Ray components along the plane normal
  always_comb begin
    case (rd_axis)
      X: begin
        org_c = org_x;
        dir_c = dir_x;
      end
      Y: begin
        org_c = org_y;
        dir_c = dir_y;
      end
      default: begin
        org_c = org_z;
        dir_c = dir_z;
      end
    endcase
  end

  // Strict compare so an earlier object wins a tie
  assign closer = !div_zero && (div_quot >= `T_MIN) && (!found || div_quot < best_t);

  fixed_divider t_div (
    .clk(clk),
    .rst(rst),
    .start(div_start),
    .num(rd_offset - org_c),
    .den(dir_c),
    .quot(div_quot),
    .zero(div_zero),
    .done(div_done)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= S_IDLE;
      idx <= '0;
      found <= 1'b0;
      hit_valid <= 1'b0;
      hit_any <= 1'b0;
    end else begin
      hit_valid <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start) begin
            idx <= '0;
            found <= 1'b0;
            if (num_objs == '0) begin
              // Empty scene
              hit_any <= 1'b0;
              hit_valid <= 1'b1;
            end else begin
              state <= S_FETCH;
            end
          end
        end
        // Address is out, data lands at the end of this cycle
        S_FETCH: state <= S_SETUP;
        S_SETUP: state <= S_DIV;
        S_DIV: begin
          if (div_done) begin
            if (closer) begin
              found <= 1'b1;
              best_t <= div_quot;
              best_axis <= rd_axis;
              best_emit <= rd_emit;
              best_reflect <= rd_reflect;
            end
            if (obj_idx_t'(idx + 1'b1) == num_objs) begin
              state <= S_POS;
            end else begin
              idx <= idx + 1'b1;
              state <= S_FETCH;
            end
          end
        end
        S_POS: begin
          hit_any <= found;
          hit_valid <= 1'b1;
          state <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Hit record, only meaningful when hit_any
  always_ff @(posedge clk) begin
    if (state == S_POS) begin
      hit_pos_x <= org_x + q_mul(best_t, dir_x);
      hit_pos_y <= org_y + q_mul(best_t, dir_y);
      hit_pos_z <= org_z + q_mul(best_t, dir_z);
      hit_axis <= best_axis;
      hit_emit <= best_emit;
      hit_reflect <= best_reflect;
    end
  end
endmodule

`default_nettype wire

//--- ray_reflector.sv
`default_nettype none

module ray_reflector (
  input wire clk,
  input wire rst,
  input wire start,
  input wire ray_tracer_pkg::coord_t dir_x, dir_y, dir_z,
  input wire ray_tracer_pkg::color_t ray_color,
  input wire ray_tracer_pkg::color_t income_light,
  input wire ray_tracer_pkg::axis_t hit_axis,
  input wire ray_tracer_pkg::color_t hit_emit,
  input wire ray_tracer_pkg::color_t hit_reflect,
  output ray_tracer_pkg::coord_t new_dir_x, new_dir_y, new_dir_z,
  output ray_tracer_pkg::color_t new_color,
  output ray_tracer_pkg::color_t new_light,
  output logic reflect_done
);
  import ray_tracer_pkg::*;

  logic stage_v;
  color_t emit_prod;

  // 255 is one, so 255 * 255 gives 254
  function automatic chan_t chan_mul(input chan_t a, input chan_t b);
    logic [15:0] prod;
    prod = a * b;
    return prod[15:8];
  endfunction

  function automatic chan_t chan_sat(input chan_t a, input chan_t b);
    logic [8:0] sum;
    sum = a + b;
    return sum[8] ? 8'hff : sum[7:0];
  endfunction

  // Stage one, mirror and filter
  always_ff @(posedge clk) begin
    if (start) begin
      new_dir_x <= (hit_axis == X) ? -dir_x : dir_x;
      new_dir_y <= (hit_axis == Y) ? -dir_y : dir_y;
      new_dir_z <= (hit_axis == Z) ? -dir_z : dir_z;
      new_color.r <= chan_mul(ray_color.r, hit_reflect.r);
      new_color.g <= chan_mul(ray_color.g, hit_reflect.g);
      new_color.b <= chan_mul(ray_color.b, hit_reflect.b);
      emit_prod.r <= chan_mul(ray_color.r, hit_emit.r);
      emit_prod.g <= chan_mul(ray_color.g, hit_emit.g);
      emit_prod.b <= chan_mul(ray_color.b, hit_emit.b);
    end
    // Stage two, accumulate light
    if (stage_v) begin
      new_light.r <= chan_sat(income_light.r, emit_prod.r);
      new_light.g <= chan_sat(income_light.g, emit_prod.g);
      new_light.b <= chan_sat(income_light.b, emit_prod.b);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      stage_v <= 1'b0;
      reflect_done <= 1'b0;
    end else begin
      stage_v <= start;
      reflect_done <= stage_v;
    end
  end
endmodule

`default_nettype wire

//--- ray_tracer.f
+incdir+.
ray_tracer_pkg.sv
fixed_divider.sv
scene_buffer.sv
ray_intersector.sv
ray_reflector.sv
ray_tracer.sv
ray_tracer_top.sv
tb_checker.sv
tb_ray_tracer.sv

//--- ray_tracer.sv
`default_nettype none

`include "ray_tracer_defs.svh"

module ray_tracer (
  input wire clk,
  input wire rst,
  input wire ray_valid,
  output logic ray_ready,
  input wire ray_tracer_pkg::coord_t ray_ox, ray_oy, ray_oz,
  input wire ray_tracer_pkg::coord_t ray_dx, ray_dy, ray_dz,
  input wire [10:0] pixel_h_in,
  input wire [9:0] pixel_v_in,
  output logic pixel_valid,
  input wire pixel_ready,
  output ray_tracer_pkg::color_t pixel_color,
  output logic [10:0] pixel_h,
  output logic [9:0] pixel_v,
  input wire ray_tracer_pkg::obj_idx_t num_objs,
  output ray_tracer_pkg::obj_idx_t rd_addr,
  input wire ray_tracer_pkg::axis_t rd_axis,
  input wire ray_tracer_pkg::coord_t rd_offset,
  input wire ray_tracer_pkg::color_t rd_emit,
  input wire ray_tracer_pkg::color_t rd_reflect
);
  import ray_tracer_pkg::*;

  typedef enum logic [1:0] {IDLE, INTX, REFLECT, OUTPUT} tracer_state_t;

  tracer_state_t state;
  logic [$clog2(`MAX_BOUNCES + 1)-1:0] bounce_cnt;

  // Current ray
  coord_t cur_ox, cur_oy, cur_oz;
  coord_t cur_dx, cur_dy, cur_dz;
  color_t cur_color;
  color_t cur_light;

  logic intx_start;
  logic hit_valid;
  logic hit_any;
  coord_t hit_pos_x, hit_pos_y, hit_pos_z;
  axis_t hit_axis;
  color_t hit_emit;
  color_t hit_reflect;

  logic rflx_start;
  logic reflect_done;
  coord_t new_dir_x, new_dir_y, new_dir_z;
  color_t new_color;
  color_t new_light;

  assign ray_ready = (state == IDLE);
  assign pixel_valid = (state == OUTPUT);
  // Light is frozen once the FSM reaches OUTPUT
  assign pixel_color = cur_light;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
      intx_start <= 1'b0;
      rflx_start <= 1'b0;
      bounce_cnt <= '0;
    end else begin
      intx_start <= 1'b0;
      rflx_start <= 1'b0;
      case (state)
        IDLE: begin
          if (ray_valid) begin
            bounce_cnt <= '0;
            intx_start <= 1'b1;
            state <= INTX;
          end
        end
        INTX: begin
          if (hit_valid) begin
            if (hit_any) begin
              rflx_start <= 1'b1;
              state <= REFLECT;
            end else begin
              // Missed everything
              state <= OUTPUT;
            end
          end
        end
        REFLECT: begin
          if (reflect_done) begin
            if (bounce_cnt == `MAX_BOUNCES - 1) begin
              state <= OUTPUT;
            end else begin
              bounce_cnt <= bounce_cnt + 1'b1;
              intx_start <= 1'b1;
              state <= INTX;
            end
          end
        end
        OUTPUT: begin
          if (pixel_ready) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Ray payload
  always_ff @(posedge clk) begin
    if (state == IDLE && ray_valid) begin
      {cur_ox, cur_oy, cur_oz} <= {ray_ox, ray_oy, ray_oz};
      {cur_dx, cur_dy, cur_dz} <= {ray_dx, ray_dy, ray_dz};
      pixel_h <= pixel_h_in;
      pixel_v <= pixel_v_in;
      cur_color <= '1;
      cur_light <= '0;
    end
    // Next bounce leaves from the hit point
    if (state == INTX && hit_valid && hit_any) begin
      {cur_ox, cur_oy, cur_oz} <= {hit_pos_x, hit_pos_y, hit_pos_z};
    end
    if (state == REFLECT && reflect_done) begin
      {cur_dx, cur_dy, cur_dz} <= {new_dir_x, new_dir_y, new_dir_z};
      cur_color <= new_color;
      cur_light <= new_light;
    end
  end

  ray_intersector intx (
    .clk(clk),
    .rst(rst),
    .start(intx_start),
    .org_x(cur_ox), .org_y(cur_oy), .org_z(cur_oz),
    .dir_x(cur_dx), .dir_y(cur_dy), .dir_z(cur_dz),
    .num_objs(num_objs),
    .rd_addr(rd_addr),
    .rd_axis(rd_axis),
    .rd_offset(rd_offset),
    .rd_emit(rd_emit),
    .rd_reflect(rd_reflect),
    .hit_valid(hit_valid),
    .hit_any(hit_any),
    .hit_pos_x(hit_pos_x), .hit_pos_y(hit_pos_y), .hit_pos_z(hit_pos_z),
    .hit_axis(hit_axis),
    .hit_emit(hit_emit),
    .hit_reflect(hit_reflect)
  );

  ray_reflector rflx (
    .clk(clk),
    .rst(rst),
    .start(rflx_start),
    .dir_x(cur_dx), .dir_y(cur_dy), .dir_z(cur_dz),
    .ray_color(cur_color),
    .income_light(cur_light),
    .hit_axis(hit_axis),
    .hit_emit(hit_emit),
    .hit_reflect(hit_reflect),
    .new_dir_x(new_dir_x), .new_dir_y(new_dir_y), .new_dir_z(new_dir_z),
    .new_color(new_color),
    .new_light(new_light),
    .reflect_done(reflect_done)
  );
endmodule

`default_nettype wire

//--- ray_tracer_defs.svh
`ifndef RAY_TRACER_DEFS_SVH
`define RAY_TRACER_DEFS_SVH

// Q8.8 signed coordinates
`define COORD_W 16
`define FRAC_W 8

// Reflections before a ray is retired
`define MAX_BOUNCES 4

// Scene buffer depth in objects
`define MAX_OBJS 8

// One quotient bit per step, numerator is COORD_W + FRAC_W bits
`define DIV_STEPS 24

// 1/16 in Q8.8, keeps a ray off the plane it just left
`define T_MIN 16

`endif

//--- ray_tracer_pkg.sv
`default_nettype none

`include "ray_tracer_defs.svh"

package ray_tracer_pkg;

  // Signed Q8.8
  typedef logic signed [`COORD_W-1:0] coord_t;

  // 255 stands for one
  typedef logic [7:0] chan_t;

  typedef struct packed {
    chan_t r;
    chan_t g;
    chan_t b;
  } color_t;

  // Plane normal axis
  typedef enum logic [1:0] {X, Y, Z} axis_t;

  // Must also hold the count itself
  typedef logic [$clog2(`MAX_OBJS + 1)-1:0] obj_idx_t;

endpackage

`default_nettype wire

//--- ray_tracer_top.sv
`default_nettype none

module ray_tracer_top (
  input wire clk,
  input wire rst,
  // Ray in
  input wire ray_valid,
  output logic ray_ready,
  input wire ray_tracer_pkg::coord_t ray_ox, ray_oy, ray_oz,
  input wire ray_tracer_pkg::coord_t ray_dx, ray_dy, ray_dz,
  input wire [10:0] pixel_h_in,
  input wire [9:0] pixel_v_in,
  // Pixel out
  output logic pixel_valid,
  input wire pixel_ready,
  output ray_tracer_pkg::color_t pixel_color,
  output logic [10:0] pixel_h,
  output logic [9:0] pixel_v,
  // Scene load, only while ray_ready
  input wire obj_wr_en,
  input wire ray_tracer_pkg::obj_idx_t obj_wr_addr,
  input wire ray_tracer_pkg::axis_t obj_wr_axis,
  input wire ray_tracer_pkg::coord_t obj_wr_offset,
  input wire ray_tracer_pkg::color_t obj_wr_emit,
  input wire ray_tracer_pkg::color_t obj_wr_reflect,
  input wire num_objs_wr_en,
  input wire ray_tracer_pkg::obj_idx_t num_objs_in
);
  import ray_tracer_pkg::*;

  obj_idx_t num_objs;
  obj_idx_t rd_addr;
  axis_t rd_axis;
  coord_t rd_offset;
  color_t rd_emit;
  color_t rd_reflect;

  ray_tracer tracer (
    .clk(clk),
    .rst(rst),
    .ray_valid(ray_valid),
    .ray_ready(ray_ready),
    .ray_ox(ray_ox), .ray_oy(ray_oy), .ray_oz(ray_oz),
    .ray_dx(ray_dx), .ray_dy(ray_dy), .ray_dz(ray_dz),
    .pixel_h_in(pixel_h_in),
    .pixel_v_in(pixel_v_in),
    .pixel_valid(pixel_valid),
    .pixel_ready(pixel_ready),
    .pixel_color(pixel_color),
    .pixel_h(pixel_h),
    .pixel_v(pixel_v),
    .num_objs(num_objs),
    .rd_addr(rd_addr),
    .rd_axis(rd_axis),
    .rd_offset(rd_offset),
    .rd_emit(rd_emit),
    .rd_reflect(rd_reflect)
  );

  scene_buffer scene (
    .clk(clk),
    .rst(rst),
    .wr_en(obj_wr_en),
    .wr_addr(obj_wr_addr),
    .wr_axis(obj_wr_axis),
    .wr_offset(obj_wr_offset),
    .wr_emit(obj_wr_emit),
    .wr_reflect(obj_wr_reflect),
    .num_wr_en(num_objs_wr_en),
    .num_in(num_objs_in),
    .rd_addr(rd_addr),
    .rd_axis(rd_axis),
    .rd_offset(rd_offset),
    .rd_emit(rd_emit),
    .rd_reflect(rd_reflect),
    .num_objs(num_objs)
  );
endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the ray tracer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_ray_tracer -f ray_tracer.f \
  -o sim_ray_tracer > build.log 2>&1 \
  && ./obj_dir/sim_ray_tracer > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q '\*\*\* TEST PASSED \*\*\*' sim.log && exit 0 || exit 1

//--- scene_buffer.sv
`default_nettype none

`include "ray_tracer_defs.svh"

module scene_buffer (
  input wire clk,
  input wire rst,
  input wire wr_en,
  input wire ray_tracer_pkg::obj_idx_t wr_addr,
  input wire ray_tracer_pkg::axis_t wr_axis,
  input wire ray_tracer_pkg::coord_t wr_offset,
  input wire ray_tracer_pkg::color_t wr_emit,
  input wire ray_tracer_pkg::color_t wr_reflect,
  input wire num_wr_en,
  input wire ray_tracer_pkg::obj_idx_t num_in,
  input wire ray_tracer_pkg::obj_idx_t rd_addr,
  output ray_tracer_pkg::axis_t rd_axis,
  output ray_tracer_pkg::coord_t rd_offset,
  output ray_tracer_pkg::color_t rd_emit,
  output ray_tracer_pkg::color_t rd_reflect,
  output ray_tracer_pkg::obj_idx_t num_objs
);
  import ray_tracer_pkg::*;

  localparam int ADDR_W = $clog2(`MAX_OBJS);

  // One array per object field
  axis_t axis_mem [`MAX_OBJS];
  coord_t offset_mem [`MAX_OBJS];
  color_t emit_mem [`MAX_OBJS];
  color_t reflect_mem [`MAX_OBJS];

  always_ff @(posedge clk) begin
    if (wr_en && wr_addr < `MAX_OBJS) begin
      axis_mem[wr_addr[ADDR_W-1:0]] <= wr_axis;
      offset_mem[wr_addr[ADDR_W-1:0]] <= wr_offset;
      emit_mem[wr_addr[ADDR_W-1:0]] <= wr_emit;
      reflect_mem[wr_addr[ADDR_W-1:0]] <= wr_reflect;
    end
    rd_axis <= axis_mem[rd_addr[ADDR_W-1:0]];
    rd_offset <= offset_mem[rd_addr[ADDR_W-1:0]];
    rd_emit <= emit_mem[rd_addr[ADDR_W-1:0]];
    rd_reflect <= reflect_mem[rd_addr[ADDR_W-1:0]];
  end

  // Object count, clamped to the buffer depth
  always_ff @(posedge clk) begin
    if (rst) begin
      num_objs <= '0;
    end else if (num_wr_en) begin
      num_objs <= (num_in > `MAX_OBJS) ? obj_idx_t'(`MAX_OBJS) : num_in;
    end
  end
endmodule

`default_nettype wire

//--- tb_checker.sv
`default_nettype none

module tb_checker #(
  parameter int NUM_CASES = 1,
  parameter int WAIT_LIMIT = 3000
) (
  input wire clk,
  input wire rst,
  input wire ray_valid,
  input wire ray_ready,
  input wire pixel_valid,
  input wire pixel_ready,
  input wire [23:0] pixel_color,
  input wire [10:0] pixel_h,
  input wire [9:0] pixel_v,
  input wire [NUM_CASES-1:0][23:0] exp_color,
  input wire [NUM_CASES-1:0][10:0] exp_h,
  input wire [NUM_CASES-1:0][9:0] exp_v,
  output int errors,
  output int pixels
);
  timeunit 1ns;
  timeprecision 1ps;

  int rays;
  int wait_cycles;

  // Pixel seen last edge while the sink stalled
  logic held;
  logic [23:0] held_color;
  logic [10:0] held_h;
  logic [9:0] held_v;

  task automatic check_value(input string name, input logic [23:0] got,
                             input logic [23:0] exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h at pixel %0d", name, got, exp, pixels);
      errors++;
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      errors = 0;
      pixels <= 0;
      rays <= 0;
      wait_cycles <= 0;
      held <= 1'b0;
    end else begin
      // Outputs must not move during a stall
      if (held) begin
        if (!pixel_valid) begin
          $display("pixel_valid dropped before pixel %0d was taken", pixels);
          errors++;
        end else begin
          check_value("pixel_color", pixel_color, held_color);
          check_value("pixel_h", 24'(pixel_h), 24'(held_h));
          check_value("pixel_v", 24'(pixel_v), 24'(held_v));
        end
      end
      if (pixel_valid && ray_ready) begin
        $display("ray_ready is high while pixel %0d is still pending", pixels);
        errors++;
      end

      if (pixel_valid && pixel_ready) begin
        if (pixels >= NUM_CASES) begin
          $display("An extra pixel was delivered beyond the %0d expected", NUM_CASES);
          errors++;
        end else begin
          check_value("pixel_color", pixel_color, exp_color[pixels]);
          check_value("pixel_h", 24'(pixel_h), 24'(exp_h[pixels]));
          check_value("pixel_v", 24'(pixel_v), 24'(exp_v[pixels]));
        end
        pixels <= pixels + 1;
      end
      if (ray_valid && ray_ready) begin
        rays <= rays + 1;
      end

      // Watchdog on an accepted ray
      if (pixel_valid && pixel_ready) begin
        wait_cycles <= 0;
      end else if (rays > pixels) begin
        wait_cycles <= wait_cycles + 1;
        if (wait_cycles == WAIT_LIMIT) begin
          $display("Pixel %0d never arrived within %0d cycles", pixels, WAIT_LIMIT);
          errors++;
        end
      end else begin
        wait_cycles <= 0;
      end

      held <= pixel_valid && !pixel_ready;
      held_color <= pixel_color;
      held_h <= pixel_h;
      held_v <= pixel_v;
    end
  end
endmodule

`default_nettype wire

//--- tb_ray_tracer.sv
`default_nettype none

module tb_ray_tracer;
  timeunit 1ns;
  timeprecision 1ps;

  import ray_tracer_pkg::*;

  localparam int NUM_CASES = 6;
  localparam int CASE_OBJS = 4;
  localparam int WAIT_LIMIT = 3000;

  logic clk;
  logic rst;
  logic ray_valid;
  logic ray_ready;
  coord_t ray_ox, ray_oy, ray_oz;
  coord_t ray_dx, ray_dy, ray_dz;
  logic [10:0] pixel_h_in;
  logic [9:0] pixel_v_in;
  logic pixel_valid;
  logic pixel_ready;
  color_t pixel_color;
  logic [10:0] pixel_h;
  logic [9:0] pixel_v;
  logic obj_wr_en;
  obj_idx_t obj_wr_addr;
  axis_t obj_wr_axis;
  coord_t obj_wr_offset;
  color_t obj_wr_emit;
  color_t obj_wr_reflect;
  logic num_objs_wr_en;
  obj_idx_t num_objs_in;

  // Stimulus and expected pixels, one row per case
  int case_objs [NUM_CASES];
  axis_t tab_axis [NUM_CASES][CASE_OBJS];
  coord_t tab_offset [NUM_CASES][CASE_OBJS];
  color_t tab_emit [NUM_CASES][CASE_OBJS];
  color_t tab_reflect [NUM_CASES][CASE_OBJS];
  coord_t tab_org [NUM_CASES][3];
  coord_t tab_dir [NUM_CASES][3];
  logic [NUM_CASES-1:0][23:0] exp_color;
  logic [NUM_CASES-1:0][10:0] exp_h;
  logic [NUM_CASES-1:0][9:0] exp_v;

  logic [31:0] stall_lfsr;
  int timeouts;
  int chk_errors;
  int chk_pixels;

  ray_tracer_top dut (
    .clk(clk),
    .rst(rst),
    .ray_valid(ray_valid),
    .ray_ready(ray_ready),
    .ray_ox(ray_ox), .ray_oy(ray_oy), .ray_oz(ray_oz),
    .ray_dx(ray_dx), .ray_dy(ray_dy), .ray_dz(ray_dz),
    .pixel_h_in(pixel_h_in),
    .pixel_v_in(pixel_v_in),
    .pixel_valid(pixel_valid),
    .pixel_ready(pixel_ready),
    .pixel_color(pixel_color),
    .pixel_h(pixel_h),
    .pixel_v(pixel_v),
    .obj_wr_en(obj_wr_en),
    .obj_wr_addr(obj_wr_addr),
    .obj_wr_axis(obj_wr_axis),
    .obj_wr_offset(obj_wr_offset),
    .obj_wr_emit(obj_wr_emit),
    .obj_wr_reflect(obj_wr_reflect),
    .num_objs_wr_en(num_objs_wr_en),
    .num_objs_in(num_objs_in)
  );

  tb_checker #(.NUM_CASES(NUM_CASES), .WAIT_LIMIT(WAIT_LIMIT)) pixel_chk (
    .clk(clk),
    .rst(rst),
    .ray_valid(ray_valid),
    .ray_ready(ray_ready),
    .pixel_valid(pixel_valid),
    .pixel_ready(pixel_ready),
    .pixel_color(pixel_color),
    .pixel_h(pixel_h),
    .pixel_v(pixel_v),
    .exp_color(exp_color),
    .exp_h(exp_h),
    .exp_v(exp_v),
    .errors(chk_errors),
    .pixels(chk_pixels)
  );

  // Galois form, taps 32 31 29 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 32'hD000_0001;
    return n;
  endfunction

  task automatic set_object(input int c, input int j, input axis_t axis, input coord_t offset,
                            input color_t emit, input color_t refl);
    tab_axis[c][j] = axis;
    tab_offset[c][j] = offset;
    tab_emit[c][j] = emit;
    tab_reflect[c][j] = refl;
  endtask

  task automatic set_ray(input int c, input int n, input coord_t ox, input coord_t oy,
                         input coord_t oz, input coord_t dx, input coord_t dy, input coord_t dz,
                         input logic [10:0] h, input logic [9:0] v, input color_t exp);
    case_objs[c] = n;
    tab_org[c][0] = ox;
    tab_org[c][1] = oy;
    tab_org[c][2] = oz;
    tab_dir[c][0] = dx;
    tab_dir[c][1] = dy;
    tab_dir[c][2] = dz;
    exp_h[c] = h;
    exp_v[c] = v;
    exp_color[c] = exp;
  endtask

  task automatic fill_table();
    // Empty scene
    set_ray(0, 0, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0100,
            11'd12, 10'd34, 24'h000000);
    // Only plane is behind the origin
    set_object(1, 0, Z, 16'hFC00, 24'hFF0000, 24'h000000);
    set_ray(1, 1, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0100,
            11'd100, 10'd7, 24'h000000);
    // Emitter only, 255 * e >> 8 per channel
    set_object(2, 0, Z, 16'h0200, 24'hC86432, 24'h000000);
    set_ray(2, 1, 16'h0180, 16'hFE00, 16'h0000, 16'h0080, 16'h0000, 16'h0100,
            11'd640, 10'd480, 24'hC76331);
    // Far plane, plane at t = 1/32, zero denominator, then the nearest one
    set_object(3, 0, Z, 16'h0600, 24'h00FF00, 24'h000000);
    set_object(3, 1, Z, 16'h0008, 24'hFF0000, 24'h000000);
    set_object(3, 2, X, 16'h0500, 24'hFFFFFF, 24'h000000);
    set_object(3, 3, Z, 16'h0300, 24'h1080F0, 24'h000000);
    set_ray(3, 4, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0100,
            11'd33, 10'd66, 24'h0F7FEF);
    // Facing mirrors at z = 2 and z = -2, four bounces, green saturates
    for (int c = 4; c < 6; c++) begin
      set_object(c, 0, Z, 16'h0200, 24'h402010, 24'h80FFC0);
      set_object(c, 1, Z, 16'hFE00, 24'h60F008, 24'hFF8080);
    end
    set_ray(4, 2, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0100,
            11'd2047, 10'd1023, 24'hA4FF1B);
    set_ray(5, 2, 16'h0100, 16'h0100, 16'h0080, 16'h0000, 16'h0000, 16'h0100,
            11'd5, 10'd9, 24'hA4FF1B);
  endtask

  task automatic wait_ray_ready(output logic ok);
    int cycles;
    ok = 1'b0;
    cycles = 0;
    while (!ok && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      ok = ray_ready;
      cycles++;
    end
    if (!ok) begin
      $display("Timed out after %0d cycles waiting for ray_ready", WAIT_LIMIT);
      timeouts++;
    end
  endtask

  task automatic load_scene(input int c);
    for (int j = 0; j < case_objs[c]; j++) begin
      obj_wr_en <= 1'b1;
      obj_wr_addr <= obj_idx_t'(j);
      obj_wr_axis <= tab_axis[c][j];
      obj_wr_offset <= tab_offset[c][j];
      obj_wr_emit <= tab_emit[c][j];
      obj_wr_reflect <= tab_reflect[c][j];
      @(posedge clk);
    end
    obj_wr_en <= 1'b0;
    num_objs_wr_en <= 1'b1;
    num_objs_in <= obj_idx_t'(case_objs[c]);
    @(posedge clk);
    num_objs_wr_en <= 1'b0;
  endtask

  task automatic send_ray(input int c, output logic ok);
    int cycles;
    ok = 1'b0;
    cycles = 0;
    ray_valid <= 1'b1;
    ray_ox <= tab_org[c][0];
    ray_oy <= tab_org[c][1];
    ray_oz <= tab_org[c][2];
    ray_dx <= tab_dir[c][0];
    ray_dy <= tab_dir[c][1];
    ray_dz <= tab_dir[c][2];
    pixel_h_in <= exp_h[c];
    pixel_v_in <= exp_v[c];
    while (!ok && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      ok = ray_valid && ray_ready;
      cycles++;
    end
    ray_valid <= 1'b0;
    if (!ok) begin
      $display("Ray %0d was not accepted within %0d cycles", c, WAIT_LIMIT);
      timeouts++;
    end
  endtask

  task automatic wait_pixels();
    int cycles;
    cycles = 0;
    while (chk_pixels < NUM_CASES && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (chk_pixels < NUM_CASES) begin
      $display("Timed out with %0d of %0d pixels delivered", chk_pixels, NUM_CASES);
      timeouts++;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Random sink stalls, one LFSR step per bit
  initial begin
    pixel_ready = 1'b0;
    stall_lfsr = 32'h25b4;
    forever begin
      @(posedge clk);
      if (!rst) begin
        pixel_ready <= stall_lfsr[0];
        stall_lfsr = lfsr_next(stall_lfsr);
      end
    end
  end

  initial begin
    logic ok;
    timeouts = 0;
    rst = 1'b1;
    ray_valid = 1'b0;
    {ray_ox, ray_oy, ray_oz} = '0;
    {ray_dx, ray_dy, ray_dz} = '0;
    pixel_h_in = '0;
    pixel_v_in = '0;
    obj_wr_en = 1'b0;
    obj_wr_addr = '0;
    obj_wr_axis = X;
    obj_wr_offset = '0;
    obj_wr_emit = '0;
    obj_wr_reflect = '0;
    num_objs_wr_en = 1'b0;
    num_objs_in = '0;
    fill_table();
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    for (int c = 0; c < NUM_CASES; c++) begin
      wait_ray_ready(ok);
      if (!ok) break;
      load_scene(c);
      send_ray(c, ok);
      if (!ok) break;
    end
    if (timeouts == 0) wait_pixels();

    $display("Pixels checked %0d, errors %0d, timeouts %0d", chk_pixels, chk_errors, timeouts);
    if (chk_errors == 0 && timeouts == 0 && chk_pixels == NUM_CASES) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end
endmodule

`default_nettype wire
